/* include/vgen_config.svh */
// video generator configuration
// raster timing, sync polarity, fetch lead and register reset values
`ifndef VGEN_CONFIG_SVH
`define VGEN_CONFIG_SVH

// small raster mode, 64x24 visible in an 88x32 frame
`define VGEN_VISIBLE_WIDTH   11'd64     // visible pixels per line
`define VGEN_VISIBLE_HEIGHT  11'd24     // visible lines per frame

`define VGEN_H_FRONT_PORCH   11'd4      // pixels before hsync
`define VGEN_H_SYNC_PULSE    11'd8      // hsync width in pixels
`define VGEN_H_BACK_PORCH    11'd12     // pixels after hsync, before visible

`define VGEN_V_FRONT_PORCH   11'd2      // lines after visible, before vsync
`define VGEN_V_SYNC_PULSE    11'd2      // vsync width in lines
`define VGEN_V_BACK_PORCH    11'd4      // lines after vsync

`define VGEN_H_SYNC_POLARITY 1'b0       // active level of hsync
`define VGEN_V_SYNC_POLARITY 1'b0       // active level of vsync

// first fetch cycle sits this far ahead of the first pixel on the outputs
`define VGEN_FETCH_LEAD      7

`define VGEN_TILES_WIDE      16'd8      // reset line width in tiles
`define VGEN_FONT_HEIGHT     4'd15      // reset font height minus one

`endif

/* hw/vgen_pkg.sv */
// video generator shared types
// raster states, register numbers and datapath widths
`default_nettype none

package vgen_pkg;

    // raster state order, each line and frame walks these in turn
    typedef enum logic [1:0] {
        PRE_SYNC,                       // front porch
        SYNC,                           // sync pulse
        POST_SYNC,                      // back porch
        VISIBLE                         // active video
    } video_state_e;

    // register numbers on the strobe-and-number port
    typedef enum logic [3:0] {
        REG_DISPSTART  = 4'd0,          // text start word address
        REG_DISPWIDTH  = 4'd1,          // words per text row
        REG_FONTCTRL   = 4'd3,          // font bank and height
        REG_R_WIDTH    = 4'd8,          // visible width, read only
        REG_R_HEIGHT   = 4'd9,          // visible height, read only
        REG_R_SCANLINE = 4'd11          // raster position, read only
    } reg_num_e;

    typedef logic [15:0] word_t;        // register and memory word
    typedef logic [10:0] count_t;       // raster counter
    typedef logic [11:0] font_addr_t;   // font ram word address
    typedef logic [3:0]  pal_index_t;   // palette index

endpackage

`default_nettype wire

/* hw/vgen_regs.sv */
// video generator configuration registers
// write decode plus registered read mux with status words
`default_nettype none

`include "vgen_config.svh"

module vgen_regs (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire                          reg_wr_i,       // write strobe
    input  wire vgen_pkg::reg_num_e      reg_num_i,      // register select, read and write
    input  wire vgen_pkg::word_t         reg_data_i,     // write data
    input  wire vgen_pkg::video_state_e  h_state_i,      // for scanline status
    input  wire vgen_pkg::video_state_e  v_state_i,
    input  wire vgen_pkg::count_t        v_count_i,
    output vgen_pkg::word_t              reg_data_o,     // read data, one cycle behind select
    output vgen_pkg::word_t              text_start_o,
    output vgen_pkg::word_t              line_width_o,
    output logic [5:0]                   font_bank_o,
    output logic [3:0]                   font_height_o   // height minus one
);
    import vgen_pkg::*;

    // writable registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            text_start_o  <= '0;
            line_width_o  <= `VGEN_TILES_WIDE;
            font_bank_o   <= '0;
            font_height_o <= `VGEN_FONT_HEIGHT;
        end else if (reg_wr_i) begin
            case (reg_num_i)
                REG_DISPSTART: text_start_o <= reg_data_i;
                REG_DISPWIDTH: line_width_o <= reg_data_i;
                REG_FONTCTRL: begin
                    font_bank_o   <= reg_data_i[15:10];
                    font_height_o <= reg_data_i[3:0];
                end
                default: ;                                  // read only or unused, write dropped
            endcase
        end
    end

    // read mux, registered so data follows the select by one clock
    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_data_o <= '0;
        end else begin
            case (reg_num_i)
                REG_DISPSTART:  reg_data_o <= text_start_o;
                REG_DISPWIDTH:  reg_data_o <= line_width_o;
                REG_FONTCTRL:   reg_data_o <= {font_bank_o, 6'b000000, font_height_o};
                REG_R_WIDTH:    reg_data_o <= {5'b00000, `VGEN_VISIBLE_WIDTH};
                REG_R_HEIGHT:   reg_data_o <= {5'b00000, `VGEN_VISIBLE_HEIGHT};
                REG_R_SCANLINE: reg_data_o <= {(v_state_i != VISIBLE),  // set in vertical blank
                                               (h_state_i != VISIBLE),  // set in horizontal blank
                                               3'b000,
                                               v_count_i};
                default:        reg_data_o <= '0;           // unused numbers read zero
            endcase
        end
    end

    // read data stays defined whatever the select does once out of reset
    read_data_known: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown(reg_data_o))
        else $error("vgen_regs: read data unknown");

endmodule

`default_nettype wire

/* hw/vgen_sync.sv */
// raster sync generator
// h/v state machines, registered syncs and display enable, fetch window and strobes
`default_nettype none

`include "vgen_config.svh"

module vgen_sync (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      enable_i,         // sampled at frame end
    output vgen_pkg::video_state_e   h_state_o,
    output vgen_pkg::video_state_e   v_state_o,
    output vgen_pkg::count_t         v_count_o,        // line within frame
    output logic                     hsync_o,
    output logic                     vsync_o,
    output logic                     dv_de_o,
    output logic                     fetch_active_o,   // tile fetch window
    output logic                     line_start_o,     // first cycle of the window
    output logic                     line_end_o,       // last pixel of a line
    output logic                     frame_end_o,      // last pixel of a frame
    output logic                     video_on_o        // enable held for the frame
);
    import vgen_pkg::*;

    localparam count_t H_OFFSCREEN = `VGEN_H_FRONT_PORCH + `VGEN_H_SYNC_PULSE
                                   + `VGEN_H_BACK_PORCH;
    localparam count_t H_TOTAL     = H_OFFSCREEN + `VGEN_VISIBLE_WIDTH;
    localparam count_t V_TOTAL     = `VGEN_VISIBLE_HEIGHT + `VGEN_V_FRONT_PORCH
                                   + `VGEN_V_SYNC_PULSE + `VGEN_V_BACK_PORCH;
    // last count before the window opens
    localparam count_t FETCH_START = H_OFFSCREEN - count_t'(`VGEN_FETCH_LEAD);

    count_t       h_count;          // pixel within line
    count_t       h_limit;          // last count of the current h state
    count_t       v_limit;          // last line of the current v state
    video_state_e h_state_next;
    video_state_e v_state_next;
    logic         fetch_next;

    // visible comes last horizontally and first vertically
    always_comb begin
        case (h_state_o)
            PRE_SYNC:  h_limit = `VGEN_H_FRONT_PORCH - 11'd1;
            SYNC:      h_limit = `VGEN_H_FRONT_PORCH + `VGEN_H_SYNC_PULSE - 11'd1;
            POST_SYNC: h_limit = H_OFFSCREEN - 11'd1;
            default:   h_limit = H_TOTAL - 11'd1;
        endcase
        case (v_state_o)
            PRE_SYNC:  v_limit = `VGEN_VISIBLE_HEIGHT + `VGEN_V_FRONT_PORCH - 11'd1;
            SYNC:      v_limit = `VGEN_VISIBLE_HEIGHT + `VGEN_V_FRONT_PORCH
                               + `VGEN_V_SYNC_PULSE - 11'd1;
            POST_SYNC: v_limit = V_TOTAL - 11'd1;
            default:   v_limit = `VGEN_VISIBLE_HEIGHT - 11'd1;
        endcase
    end

    assign line_end_o   = (h_state_o == VISIBLE) && (h_count == h_limit);
    assign frame_end_o  = line_end_o && (v_state_o == POST_SYNC) && (v_count_o == v_limit);
    assign h_state_next = (h_count == h_limit) ? video_state_e'(h_state_o + 2'd1) : h_state_o;
    assign v_state_next = (line_end_o && v_count_o == v_limit) ?
                          video_state_e'(v_state_o + 2'd1) : v_state_o;
    // window opens on visible lines only and closes at the last count
    assign fetch_next   = fetch_active_o ? (h_count != H_TOTAL - 11'd1)
                                         : (v_state_o == VISIBLE && h_count == FETCH_START);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state_o      <= PRE_SYNC;
            v_state_o      <= VISIBLE;                     // frame starts on line 0
            h_count        <= '0;
            v_count_o      <= '0;
            fetch_active_o <= 1'b0;
            line_start_o   <= 1'b0;
            hsync_o        <= ~`VGEN_H_SYNC_POLARITY;
            vsync_o        <= ~`VGEN_V_SYNC_POLARITY;
            dv_de_o        <= 1'b0;
            video_on_o     <= 1'b1;
        end else begin
            h_state_o      <= h_state_next;
            v_state_o      <= v_state_next;
            h_count        <= line_end_o ? '0 : h_count + 11'd1;
            if (line_end_o) begin
                v_count_o  <= frame_end_o ? '0 : v_count_o + 11'd1;
            end
            fetch_active_o <= fetch_next;
            line_start_o   <= fetch_next & ~fetch_active_o;  // rising edge of window
            // outputs follow the state by one clock
            hsync_o        <= (h_state_o == SYNC) ? `VGEN_H_SYNC_POLARITY : ~`VGEN_H_SYNC_POLARITY;
            vsync_o        <= (v_state_o == SYNC) ? `VGEN_V_SYNC_POLARITY : ~`VGEN_V_SYNC_POLARITY;
            dv_de_o        <= video_on_o && (h_state_o == VISIBLE) && (v_state_o == VISIBLE);
            if (frame_end_o) begin
                video_on_o <= enable_i;                    // enable only changes between frames
            end
        end
    end

    hsync_in_window: assert property (@(posedge clk) disable iff (reset_i)
        (hsync_o == `VGEN_H_SYNC_POLARITY) ==
        ($past(h_count) >= `VGEN_H_FRONT_PORCH &&
         $past(h_count) < `VGEN_H_FRONT_PORCH + `VGEN_H_SYNC_PULSE))
        else $error("vgen_sync: hsync outside its count window");

    frame_end_wraps: assert property (@(posedge clk) disable iff (reset_i)
        frame_end_o |-> line_end_o ##1
            (h_count == '0 && v_count_o == '0 && v_state_o == VISIBLE))
        else $error("vgen_sync: frame end not followed by line 0");

endmodule

`default_nettype wire

/* hw/vgen_text_fetch.sv */
// text tile fetch and pixel pipeline
// 8-cycle vram and font ram sequence feeding a font line shift-out to palette index
`default_nettype none

module vgen_text_fetch (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      fetch_active_i,
    input  wire                      line_start_i,
    input  wire                      line_end_i,
    input  wire                      frame_end_i,
    input  wire                      video_on_i,
    input  wire vgen_pkg::word_t     text_start_i,     // first tile word of the frame
    input  wire vgen_pkg::word_t     line_width_i,     // words per text row
    input  wire [5:0]                font_bank_i,
    input  wire [3:0]                font_height_i,    // lines per tile minus one
    input  wire vgen_pkg::word_t     vram_data_i,      // colour in 15:8 and tile in 7:0
    input  wire vgen_pkg::word_t     fontram_data_i,   // two font lines with the even one high
    output logic                     vram_sel_o,
    output vgen_pkg::word_t          vram_addr_o,
    output logic                     fontram_sel_o,
    output vgen_pkg::font_addr_t     fontram_addr_o,
    output vgen_pkg::pal_index_t     pal_index_o
);
    import vgen_pkg::*;

    logic [2:0] tile_x;         // slot within the 8-cycle tile
    logic [3:0] tile_y;         // font line within the text row
    word_t      text_addr;      // next tile word to fetch
    word_t      line_addr;      // first tile word of the current row
    logic [7:0] color_save;     // colour byte waiting for its font line
    logic [7:0] text_color;     // bg in 7:4 and fg in 3:0
    logic [7:0] font_shift;     // font line with the current pixel in the msb
    logic       fetching;
    logic       slot_vram;      // slot 0 puts the tile word address out
    logic       slot_font;      // slot 2 takes the tile word and puts the font address out
    logic       slot_load;      // slot 4 loads the font line
    font_addr_t font_addr;

    // phase restarts on the window's first cycle so slot 0 lands one clock later
    assign fetching  = fetch_active_i & ~line_start_i;
    assign slot_vram = fetching && (tile_x == 3'd0);
    assign slot_font = fetching && (tile_x == 3'd2);
    assign slot_load = fetching && (tile_x == 3'd4);

    // tall fonts take a bank pair and short ones fit four banks
    assign font_addr = font_height_i[3] ? {font_bank_i[5], vram_data_i[7:0], tile_y[3:1]}
                                        : {font_bank_i[5:4], vram_data_i[7:0], tile_y[2:1]};

    // memory addresses and the pending colour
    always_ff @(posedge clk) begin
        if (slot_vram) begin
            vram_addr_o <= text_addr;
        end
        if (slot_font) begin
            color_save     <= vram_data_i[15:8];
            fontram_addr_o <= font_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o    <= 1'b0;
            fontram_sel_o <= 1'b0;
            tile_x        <= '0;
            tile_y        <= '0;
            text_addr     <= '0;
            line_addr     <= '0;
            text_color    <= '0;
            font_shift    <= '0;
            pal_index_o   <= '0;
        end else begin
            vram_sel_o    <= slot_vram & video_on_i;        // no memory traffic while off
            fontram_sel_o <= slot_font & video_on_i;
            tile_x        <= line_start_i ? 3'd0 : tile_x + 3'd1;

            if (slot_vram) begin
                text_addr <= text_addr + 16'd1;
            end
            if (slot_load) begin
                font_shift <= tile_y[0] ? fontram_data_i[7:0] : fontram_data_i[15:8];
                text_color <= color_save;
            end else if (fetching) begin
                font_shift <= {font_shift[6:0], 1'b0};
            end

            pal_index_o <= font_shift[7] ? text_color[3:0] : text_color[7:4];

            // row and frame addressing
            if (frame_end_i) begin
                tile_y    <= '0;
                line_addr <= text_start_i;
                text_addr <= text_start_i;
            end else if (line_end_i) begin
                if (tile_y == font_height_i) begin          // last font line moves to the next row
                    tile_y    <= '0;
                    line_addr <= line_addr + line_width_i;
                    text_addr <= line_addr + line_width_i;
                end else begin
                    tile_y    <= tile_y + 4'd1;
                    text_addr <= line_addr;                 // same row again
                end
            end
        end
    end

    font_follows_vram: assert property (@(posedge clk) disable iff (reset_i)
        fontram_sel_o |-> !vram_sel_o && $past(vram_sel_o, 2))
        else $error("vgen_text_fetch: font ram access out of step with its vram access");

endmodule

`default_nettype wire

/* hw/video_gen.sv */
// text-mode video generator
// register block, raster sync generator and tile fetch pipeline
`default_nettype none

module video_gen (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      enable_i,         // takes effect at next frame
    input  wire                      vgen_reg_wr_i,
    input  wire vgen_pkg::reg_num_e  vgen_reg_num_i,
    input  wire vgen_pkg::word_t     vgen_reg_data_i,
    output vgen_pkg::word_t          vgen_reg_data_o,
    output logic                     vram_sel_o,
    output vgen_pkg::word_t          vram_addr_o,
    input  wire vgen_pkg::word_t     vram_data_i,
    output logic                     fontram_sel_o,
    output vgen_pkg::font_addr_t     fontram_addr_o,
    input  wire vgen_pkg::word_t     fontram_data_i,
    output vgen_pkg::pal_index_t     pal_index_o,
    output logic                     hsync_o,
    output logic                     vsync_o,
    output logic                     dv_de_o
);
    import vgen_pkg::*;

    video_state_e h_state;
    video_state_e v_state;
    count_t       v_count;
    word_t        text_start;
    word_t        line_width;
    logic [5:0]   font_bank;
    logic [3:0]   font_height;
    logic         fetch_active;
    logic         line_start;
    logic         line_end;
    logic         frame_end;
    logic         video_on;

    vgen_regs i_vgen_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .reg_wr_i      (vgen_reg_wr_i),
        .reg_num_i     (vgen_reg_num_i),
        .reg_data_i    (vgen_reg_data_i),
        .h_state_i     (h_state),
        .v_state_i     (v_state),
        .v_count_i     (v_count),
        .reg_data_o    (vgen_reg_data_o),
        .text_start_o  (text_start),
        .line_width_o  (line_width),
        .font_bank_o   (font_bank),
        .font_height_o (font_height)
    );

    vgen_sync i_vgen_sync (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .h_state_o      (h_state),
        .v_state_o      (v_state),
        .v_count_o      (v_count),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .dv_de_o        (dv_de_o),
        .fetch_active_o (fetch_active),
        .line_start_o   (line_start),
        .line_end_o     (line_end),
        .frame_end_o    (frame_end),
        .video_on_o     (video_on)
    );

    vgen_text_fetch i_vgen_text_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .fetch_active_i (fetch_active),
        .line_start_i   (line_start),
        .line_end_i     (line_end),
        .frame_end_i    (frame_end),
        .video_on_i     (video_on),
        .text_start_i   (text_start),
        .line_width_i   (line_width),
        .font_bank_i    (font_bank),
        .font_height_i  (font_height),
        .vram_data_i    (vram_data_i),
        .fontram_data_i (fontram_data_i),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .fontram_sel_o  (fontram_sel_o),
        .fontram_addr_o (fontram_addr_o),
        .pal_index_o    (pal_index_o)
    );

endmodule

`default_nettype wire

/* dv/vgen_mem_model.sv */
// VRAM and font RAM models for the video generator testbench
// one-cycle read latency, contents filled from an LCG sequence over the address
`default_nettype none

module vgen_mem_model (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire                      vram_sel_i,
    input  wire vgen_pkg::word_t     vram_addr_i,
    output vgen_pkg::word_t          vram_data_o,      // colour byte high, tile byte low
    input  wire                      fontram_sel_i,
    input  wire vgen_pkg::font_addr_t fontram_addr_i,
    output vgen_pkg::word_t          fontram_data_o    // even font line high byte
);
    timeunit 1ns;
    timeprecision 100ps;
    import vgen_pkg::*;

    word_t vram_mem [0:65535];      // one word per tile address
    word_t font_mem [0:4095];       // two font lines per word
    int    vram_reads;              // sel pulses seen
    int    font_reads;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // each address gets its own step of the sequence
    initial begin
        logic [31:0] state;
        state = 32'h78df_0f6d;
        for (int a = 0; a < 65536; a++) begin
            state       = lcg_next(state);
            vram_mem[a] = state[31:16];
        end
        for (int a = 0; a < 4096; a++) begin
            state       = lcg_next(state);
            font_mem[a] = state[31:16];
        end
    end

    always @(posedge clk) begin
        if (reset_i) begin
            vram_data_o    <= '0;
            fontram_data_o <= '0;
            vram_reads     <= 0;
            font_reads     <= 0;
        end else begin
            if (vram_sel_i) begin
                vram_data_o <= vram_mem[vram_addr_i];       // held until the next access
                vram_reads  <= vram_reads + 1;
            end
            if (fontram_sel_i) begin
                fontram_data_o <= font_mem[fontram_addr_i];
                font_reads     <= font_reads + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/video_gen_tb.sv */
// video generator testbench
// directed register, raster, rendering, reconfig, disable and scanline tests
`default_nettype none

`include "vgen_config.svh"

module video_gen_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import vgen_pkg::*;

    localparam int LINE_CYCLES  = 88;
    localparam int FRAME_CYCLES = LINE_CYCLES * 32;
    localparam int CYCLE_LIMIT  = 12 * FRAME_CYCLES;    // about 9 frames of tests plus margin

    logic         clk;
    logic         reset_i;
    logic         enable_i;
    logic         reg_wr;
    reg_num_e     reg_num;
    word_t        reg_wdata;
    word_t        reg_rdata;
    logic         vram_sel;
    word_t        vram_addr;
    word_t        vram_data;
    logic         fontram_sel;
    font_addr_t   fontram_addr;
    word_t        fontram_data;
    pal_index_t   pal_index;
    logic         hsync;
    logic         vsync;
    logic         dv_de;

    int           errors;
    int           checks;
    int           cycles;

    video_gen i_video_gen (
        .clk             (clk),
        .reset_i         (reset_i),
        .enable_i        (enable_i),
        .vgen_reg_wr_i   (reg_wr),
        .vgen_reg_num_i  (reg_num),
        .vgen_reg_data_i (reg_wdata),
        .vgen_reg_data_o (reg_rdata),
        .vram_sel_o      (vram_sel),
        .vram_addr_o     (vram_addr),
        .vram_data_i     (vram_data),
        .fontram_sel_o   (fontram_sel),
        .fontram_addr_o  (fontram_addr),
        .fontram_data_i  (fontram_data),
        .pal_index_o     (pal_index),
        .hsync_o         (hsync),
        .vsync_o         (vsync),
        .dv_de_o         (dv_de)
    );

    vgen_mem_model i_mem (
        .clk            (clk),
        .reset_i        (reset_i),
        .vram_sel_i     (vram_sel),
        .vram_addr_i    (vram_addr),
        .vram_data_o    (vram_data),
        .fontram_sel_i  (fontram_sel),
        .fontram_addr_i (fontram_addr),
        .fontram_data_o (fontram_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                          // 8 ns period
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @%0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pal(input string name, input pal_index_t got, input pal_index_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @%0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @%0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error @%0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input reg_num_e num, input word_t data);
        @(posedge clk);
        #1;
        reg_wr    = 1'b1;
        reg_num   = num;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr    = 1'b0;
    endtask

    // select goes out and is captured on the next edge, then sampled at the falling edge
    task automatic read_reg(input reg_num_e num, output word_t data);
        @(posedge clk);
        #1;
        reg_num = num;
        @(posedge clk);
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic expect_reg(input string name, input reg_num_e num, input word_t exp);
        word_t data;
        read_reg(num, data);
        check_word(name, data, exp);
    endtask

    // pixel value from the column, font line and colour rules
    function automatic pal_index_t expected_pixel(input word_t start, input word_t width,
                                                  input logic [5:0] bank, input logic [3:0] hm1,
                                                  input int y, input int k);
        int         row;
        logic [3:0] ty;
        word_t      taddr;
        word_t      vw;
        word_t      fw;
        font_addr_t fa;
        logic [7:0] fline;
        row   = y / (int'(hm1) + 1);
        ty    = 4'(y % (int'(hm1) + 1));
        taddr = start + word_t'(row) * width + word_t'(k / 8);
        vw    = i_mem.vram_mem[taddr];
        if (hm1 >= 4'd8)
            fa = {bank[5], vw[7:0], ty[3:1]};
        else
            fa = {bank[5:4], vw[7:0], ty[2:1]};
        fw    = i_mem.font_mem[fa];
        fline = ty[0] ? fw[7:0] : fw[15:8];             // odd lines in the low byte
        return fline[7 - (k % 8)] ? vw[11:8] : vw[15:12];
    endfunction

    // checks every enabled pixel of the next frame that starts after vsync
    task automatic render_frame(input word_t start, input word_t width,
                                input logic [5:0] bank, input logic [3:0] hm1);
        @(negedge clk);
        while (vsync !== `VGEN_V_SYNC_POLARITY) @(negedge clk);
        for (int y = 0; y < 24; y++) begin
            while (dv_de !== 1'b1) @(negedge clk);
            for (int k = 0; k < 64; k++) begin
                check_bit("dv_de_o", dv_de, 1'b1);
                check_pal("pal_index_o", pal_index, expected_pixel(start, width, bank, hm1, y, k));
                @(negedge clk);
            end
            check_bit("dv_de_o", dv_de, 1'b0);          // exactly 64 pixels
        end
    endtask

    task automatic test_registers();
        expect_reg("reg DISPSTART", REG_DISPSTART, 16'h0000);
        expect_reg("reg DISPWIDTH", REG_DISPWIDTH, 16'd8);
        expect_reg("reg FONTCTRL", REG_FONTCTRL, 16'h000f);
        expect_reg("reg R_WIDTH", REG_R_WIDTH, 16'd64);
        expect_reg("reg R_HEIGHT", REG_R_HEIGHT, 16'd24);
        expect_reg("reg unused 5", reg_num_e'(4'd5), 16'h0000);
        write_reg(REG_DISPSTART, 16'h1234);
        write_reg(REG_DISPWIDTH, 16'h0020);
        write_reg(REG_FONTCTRL, 16'hffff);
        write_reg(REG_R_WIDTH, 16'hffff);
        write_reg(REG_R_HEIGHT, 16'h5555);
        expect_reg("reg DISPSTART", REG_DISPSTART, 16'h1234);
        expect_reg("reg DISPWIDTH", REG_DISPWIDTH, 16'h0020);
        expect_reg("reg FONTCTRL", REG_FONTCTRL, 16'hfc0f);  // middle bits read zero
        expect_reg("reg R_WIDTH", REG_R_WIDTH, 16'd64);
        expect_reg("reg R_HEIGHT", REG_R_HEIGHT, 16'd24);
    endtask

    // totals over any two whole frames are fixed
    task automatic test_raster();
        int hs_active;
        int vs_active;
        int de_cycles;
        int de_lines;
        int hs_edge;
        int de_run;
        int vs_run;
        logic hs_prev;
        logic de_prev;
        logic vs_prev;
        hs_active = 0;
        vs_active = 0;
        de_cycles = 0;
        de_lines  = 0;
        hs_edge   = -1;
        de_run    = -1;
        vs_run    = -1;
        @(negedge clk);
        hs_prev = hsync;
        de_prev = dv_de;
        vs_prev = vsync;
        for (int n = 0; n < 2 * FRAME_CYCLES; n++) begin
            if (hsync === `VGEN_H_SYNC_POLARITY) hs_active++;
            if (vsync === `VGEN_V_SYNC_POLARITY) vs_active++;
            if (dv_de === 1'b1) de_cycles++;
            if (hsync === `VGEN_H_SYNC_POLARITY && hs_prev !== `VGEN_H_SYNC_POLARITY) begin
                if (hs_edge >= 0) check_count("hsync period", n - hs_edge, LINE_CYCLES);
                hs_edge = n;
            end
            if (dv_de === 1'b1 && de_prev !== 1'b1) begin
                de_lines++;
                de_run = n;
            end
            if (dv_de !== 1'b1 && de_prev === 1'b1 && de_run >= 0)
                check_count("dv_de_o run", n - de_run, 64);
            if (vsync === `VGEN_V_SYNC_POLARITY && vs_prev !== `VGEN_V_SYNC_POLARITY) vs_run = n;
            if (vsync !== `VGEN_V_SYNC_POLARITY && vs_prev === `VGEN_V_SYNC_POLARITY && vs_run >= 0)
                check_count("vsync run", n - vs_run, 2 * LINE_CYCLES);
            hs_prev = hsync;
            de_prev = dv_de;
            vs_prev = vsync;
            @(negedge clk);
        end
        check_count("hsync active cycles", hs_active, 2 * 32 * 8);
        check_count("vsync active cycles", vs_active, 2 * 2 * LINE_CYCLES);
        check_count("dv_de_o cycles", de_cycles, 2 * 24 * 64);
        check_count("dv_de_o lines", de_lines, 2 * 24);
    endtask

    task automatic test_reconfig();
        @(negedge clk);
        while (vsync !== `VGEN_V_SYNC_POLARITY) @(negedge clk);
        write_reg(REG_DISPSTART, 16'h0123);             // picked up at frame end
        write_reg(REG_DISPWIDTH, 16'd10);
        write_reg(REG_FONTCTRL, {6'b101101, 6'b000000, 4'd7});
        render_frame(16'h0123, 16'd10, 6'b101101, 4'd7);
    endtask

    task automatic test_disable();
        int vram_before;
        int font_before;
        int de_seen;
        @(posedge clk);
        #1;
        enable_i = 1'b0;
        @(negedge clk);
        while (vsync !== `VGEN_V_SYNC_POLARITY) @(negedge clk);
        vram_before = i_mem.vram_reads;
        font_before = i_mem.font_reads;
        de_seen     = 0;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            if (dv_de !== 1'b0) de_seen++;
            @(negedge clk);
        end
        check_count("dv_de_o cycles while off", de_seen, 0);
        check_count("vram sel pulses while off", i_mem.vram_reads - vram_before, 0);
        check_count("fontram sel pulses while off", i_mem.font_reads - font_before, 0);
        @(posedge clk);
        #1;
        enable_i = 1'b1;                                // back on at the coming frame end
        render_frame(16'h0123, 16'd10, 6'b101101, 4'd7);
    endtask

    task automatic test_scanline();
        word_t data;
        @(negedge clk);
        while (dv_de !== 1'b1) @(negedge clk);
        repeat (10) @(negedge clk);                     // well inside the line
        read_reg(REG_R_SCANLINE, data);
        check_bit("scanline bit 15 visible", data[15], 1'b0);
        check_bit("scanline bit 14 visible", data[14], 1'b0);
        check_bit("scanline count below 24", data[10:0] < 11'd24, 1'b1);
        while (vsync !== `VGEN_V_SYNC_POLARITY) @(negedge clk);
        read_reg(REG_R_SCANLINE, data);
        check_bit("scanline bit 15 blank", data[15], 1'b1);
        check_bit("scanline count in blank", data[10:0] >= 11'd24, 1'b1);
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        reset_i   = 1'b1;
        enable_i  = 1'b1;
        reg_wr    = 1'b0;
        reg_num   = REG_DISPSTART;
        reg_wdata = '0;
        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;
        @(negedge clk);
        check_bit("hsync_o idle", hsync, ~`VGEN_H_SYNC_POLARITY);
        check_bit("vsync_o idle", vsync, ~`VGEN_V_SYNC_POLARITY);
        check_bit("dv_de_o idle", dv_de, 1'b0);
        check_bit("vram_sel_o idle", vram_sel, 1'b0);
        check_bit("fontram_sel_o idle", fontram_sel, 1'b0);
        check_pal("pal_index_o idle", pal_index, 4'h0);
        test_registers();
        test_raster();
        render_frame(16'h1234, 16'h0020, 6'b111111, 4'd15);
        test_reconfig();
        test_disable();
        test_scanline();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hw/vgen_pkg.sv
hw/vgen_regs.sv
hw/vgen_sync.sv
hw/vgen_text_fetch.sv
hw/video_gen.sv
dv/vgen_mem_model.sv
dv/video_gen_tb.sv
